// ==== rtl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    localparam int word_size       = 4;
    localparam int line_size       = 16;
    localparam int words_per_line  = 4;
    localparam int num_banks       = 2;
    localparam int sets_per_bank   = 8;
    localparam int word_addr_width = 16;
    localparam int core_tag_width  = 8;

    // Derived field widths
    localparam int word_width      = word_size * 8;
    localparam int line_width      = line_size * 8;
    localparam int word_sel_width  = $clog2(words_per_line);
    localparam int bank_width      = $clog2(num_banks);
    localparam int set_width       = $clog2(sets_per_bank);
    localparam int line_addr_width = word_addr_width - word_sel_width;
    localparam int addr_tag_width  = line_addr_width - bank_width - set_width;

    typedef logic [word_width-1:0]      word_t;
    typedef logic [line_width-1:0]      line_t;
    typedef logic [word_size-1:0]       word_byteen_t;
    typedef logic [line_size-1:0]       line_byteen_t;
    typedef logic [word_addr_width-1:0] word_addr_t;
    typedef logic [line_addr_width-1:0] line_addr_t;
    typedef logic [set_width-1:0]       set_idx_t;
    typedef logic [bank_width-1:0]      bank_idx_t;
    typedef logic [addr_tag_width-1:0]  addr_tag_t;
    typedef logic [word_sel_width-1:0]  word_sel_t;
    typedef logic [core_tag_width-1:0]  core_tag_t;

    typedef struct packed {
        logic         rw;
        word_byteen_t byteen;
        word_addr_t   addr;
        word_t        data;
        core_tag_t    tag;
    } core_req_t;

    typedef struct packed {
        word_t     data;
        core_tag_t tag;
    } core_rsp_t;

    typedef struct packed {
        logic         rw;
        line_byteen_t byteen;
        line_addr_t   addr;
        line_t        data;
    } dram_req_t;

    // Tag carries the line address of the fill
    typedef struct packed {
        line_t      data;
        line_addr_t tag;
    } dram_rsp_t;

    // Per-bank lookup and write controls
    typedef struct packed {
        set_idx_t     set;
        addr_tag_t    tag;
        logic         fill_en;
        set_idx_t     fill_set;
        addr_tag_t    fill_tag;
        line_t        fill_line;
        logic         wr_en;
        word_sel_t    wr_sel;
        word_t        wr_word;
        word_byteen_t wr_byteen;
    } bank_ctrl_t;

    typedef struct packed {
        logic  hit;
        line_t line;
    } bank_ret_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        fill_req,
        fill_wait,
        write_thru,
        respond
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== rtl/line_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_store (
    input  logic                     clk,
    input  logic                     arst_n,

    input  cache_pkg::set_idx_t      set,
    input  cache_pkg::addr_tag_t     tag,
    output logic                     hit,
    output cache_pkg::line_t         line,

    input  logic                     fill_en,
    input  cache_pkg::set_idx_t      fill_set,
    input  cache_pkg::addr_tag_t     fill_tag,
    input  cache_pkg::line_t         fill_line,

    input  logic                     wr_en,
    input  cache_pkg::word_sel_t     wr_sel,
    input  cache_pkg::word_t         wr_word,
    input  cache_pkg::word_byteen_t  wr_byteen
);

    import cache_pkg::*;

    logic      [sets_per_bank-1:0] valid_q;
    addr_tag_t                     tag_q  [sets_per_bank];
    line_t                         line_q [sets_per_bank];

    // Combinational lookup
    assign hit  = valid_q[set] && (tag_q[set] == tag);
    assign line = line_q[set];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[fill_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[fill_set]  <= fill_tag;
            line_q[fill_set] <= fill_line;
        end else if (wr_en && hit) begin
            // Byte merge into the addressed word only
            for (int b = 0; b < word_size; b++) begin
                if (wr_byteen[b]) begin
                    line_q[set][(wr_sel*word_size + b)*8 +: 8] <= wr_word[b*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/bank_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module bank_router (
    input  cache_pkg::word_addr_t                          addr,
    input  cache_pkg::line_addr_t                          fill_tag,
    input  logic                                           fill_en,
    input  cache_pkg::line_t                               fill_line,
    input  logic                                           wr_en,
    input  cache_pkg::word_t                               wr_word,
    input  cache_pkg::word_byteen_t                        wr_byteen,
    output logic                                           hit,
    output cache_pkg::word_t                               rd_word,
    output cache_pkg::bank_ctrl_t [cache_pkg::num_banks-1:0] bank_ctrl,
    input  cache_pkg::bank_ret_t  [cache_pkg::num_banks-1:0] bank_ret
);

    import cache_pkg::*;

    addr_tag_t a_tag;
    set_idx_t  a_set;
    bank_idx_t a_bank;
    word_sel_t a_sel;
    addr_tag_t f_tag;
    set_idx_t  f_set;
    bank_idx_t f_bank;

    // Word offset, bank, set and tag from the low bits upward
    assign {a_tag, a_set, a_bank, a_sel} = addr;
    assign {f_tag, f_set, f_bank}        = fill_tag;

    always_comb begin
        for (int b = 0; b < num_banks; b++) begin
            bank_ctrl[b].set       = a_set;
            bank_ctrl[b].tag       = a_tag;
            bank_ctrl[b].fill_en   = fill_en && (f_bank == bank_idx_t'(b));
            bank_ctrl[b].fill_set  = f_set;
            bank_ctrl[b].fill_tag  = f_tag;
            bank_ctrl[b].fill_line = fill_line;
            bank_ctrl[b].wr_en     = wr_en && (a_bank == bank_idx_t'(b));
            bank_ctrl[b].wr_sel    = a_sel;
            bank_ctrl[b].wr_word   = wr_word;
            bank_ctrl[b].wr_byteen = wr_byteen;
        end
    end

    assign hit     = bank_ret[a_bank].hit;
    assign rd_word = bank_ret[a_bank].line[a_sel*word_width +: word_width];

endmodule

`default_nettype wire

// ==== rtl/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  logic                     clk,
    input  logic                     arst_n,

    input  logic                     core_req_valid,
    input  cache_pkg::core_req_t     core_req,
    output logic                     core_req_ready,

    output logic                     core_rsp_valid,
    output cache_pkg::core_rsp_t     core_rsp,
    input  logic                     core_rsp_ready,

    output logic                     dram_req_valid,
    output cache_pkg::dram_req_t     dram_req,
    input  logic                     dram_req_ready,

    input  logic                     dram_rsp_valid,
    input  cache_pkg::dram_rsp_t     dram_rsp,
    output logic                     dram_rsp_ready,

    output cache_pkg::word_addr_t    addr,
    output logic                     fill_en,
    output cache_pkg::line_t         fill_line,
    output logic                     wr_en,
    output cache_pkg::word_t         wr_word,
    output cache_pkg::word_byteen_t  wr_byteen,
    input  logic                     hit,
    input  cache_pkg::word_t         rd_word
);

    import cache_pkg::*;

    ctrl_state_t  state;
    core_req_t    req_q;
    core_rsp_t    rsp_q;
    word_sel_t    word_sel;
    line_byteen_t lane_byteen;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (core_req_valid) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (req_q.rw) begin
                        state <= write_thru;
                    end else if (hit) begin
                        state <= respond;
                    end else begin
                        state <= fill_req;
                    end
                end
                fill_req: begin
                    if (dram_req_ready) begin
                        state <= fill_wait;
                    end
                end
                // Line lands in the store and the lookup retries
                fill_wait: begin
                    if (dram_rsp_valid) begin
                        state <= lookup;
                    end
                end
                write_thru: begin
                    if (dram_req_ready) begin
                        state <= idle;
                    end
                end
                respond: begin
                    if (core_rsp_ready) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (core_req_valid && core_req_ready) begin
            req_q <= core_req;
        end
        if (state == lookup && !req_q.rw && hit) begin
            rsp_q.data <= rd_word;
            rsp_q.tag  <= req_q.tag;
        end
    end

    assign core_req_ready = (state == idle);
    assign core_rsp_valid = (state == respond);
    assign core_rsp       = rsp_q;

    assign addr      = req_q.addr;
    assign wr_en     = (state == lookup) && req_q.rw;
    assign wr_word   = req_q.data;
    assign wr_byteen = req_q.byteen;

    assign fill_en        = (state == fill_wait) && dram_rsp_valid;
    assign fill_line      = dram_rsp.data;
    assign dram_rsp_ready = (state == fill_wait);

    assign word_sel       = req_q.addr[word_sel_width-1:0];
    assign dram_req_valid = (state == fill_req) || (state == write_thru);

    always_comb begin
        lane_byteen = '0;
        lane_byteen[word_sel*word_size +: word_size] = req_q.byteen;

        dram_req.addr = req_q.addr[word_addr_width-1:word_sel_width];
        if (state == write_thru) begin
            dram_req.rw     = 1'b1;
            dram_req.byteen = lane_byteen;
            dram_req.data   = {words_per_line{req_q.data}};
        end else begin
            // Fill reads the whole line
            dram_req.rw     = 1'b0;
            dram_req.byteen = '1;
            dram_req.data   = '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                  clk,
    input  logic                  arst_n,

    input  logic                  core_req_valid,
    input  cache_pkg::core_req_t  core_req,
    output logic                  core_req_ready,

    output logic                  core_rsp_valid,
    output cache_pkg::core_rsp_t  core_rsp,
    input  logic                  core_rsp_ready,

    output logic                  dram_req_valid,
    output cache_pkg::dram_req_t  dram_req,
    input  logic                  dram_req_ready,

    input  logic                  dram_rsp_valid,
    input  cache_pkg::dram_rsp_t  dram_rsp,
    output logic                  dram_rsp_ready
);

    import cache_pkg::*;

    word_addr_t   req_addr;
    logic         fill_en;
    line_t        fill_line;
    logic         wr_en;
    word_t        wr_word;
    word_byteen_t wr_byteen;
    logic         hit;
    word_t        rd_word;

    bank_ctrl_t [num_banks-1:0] bank_ctrl;
    bank_ret_t  [num_banks-1:0] bank_ret;

    cache_ctrl ctrl_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp       (dram_rsp),
        .dram_rsp_ready (dram_rsp_ready),
        .addr           (req_addr),
        .fill_en        (fill_en),
        .fill_line      (fill_line),
        .wr_en          (wr_en),
        .wr_word        (wr_word),
        .wr_byteen      (wr_byteen),
        .hit            (hit),
        .rd_word        (rd_word)
    );

    // Fill bank comes straight from the DRAM response tag
    bank_router router_inst (
        .addr      (req_addr),
        .fill_tag  (dram_rsp.tag),
        .fill_en   (fill_en),
        .fill_line (fill_line),
        .wr_en     (wr_en),
        .wr_word   (wr_word),
        .wr_byteen (wr_byteen),
        .hit       (hit),
        .rd_word   (rd_word),
        .bank_ctrl (bank_ctrl),
        .bank_ret  (bank_ret)
    );

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        line_store store_inst (
            .clk       (clk),
            .arst_n    (arst_n),
            .set       (bank_ctrl[b].set),
            .tag       (bank_ctrl[b].tag),
            .hit       (bank_ret[b].hit),
            .line      (bank_ret[b].line),
            .fill_en   (bank_ctrl[b].fill_en),
            .fill_set  (bank_ctrl[b].fill_set),
            .fill_tag  (bank_ctrl[b].fill_tag),
            .fill_line (bank_ctrl[b].fill_line),
            .wr_en     (bank_ctrl[b].wr_en),
            .wr_sel    (bank_ctrl[b].wr_sel),
            .wr_word   (bank_ctrl[b].wr_word),
            .wr_byteen (bank_ctrl[b].wr_byteen)
        );
    end

endmodule

`default_nettype wire

// ==== verification/cache_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_checker (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 core_req_ready,
    input logic                 core_rsp_valid,
    input cache_pkg::core_rsp_t core_rsp,
    input logic                 core_rsp_ready,
    input logic                 dram_req_valid,
    input cache_pkg::dram_req_t dram_req,
    input logic                 dram_req_ready,
    input logic                 dram_rsp_ready
);

    int fail_count = 0;

    assert property (@(posedge clk) disable iff (!arst_n)
        core_rsp_valid && !core_rsp_ready |=> core_rsp_valid && $stable(core_rsp))
    else begin
        $error("core response dropped or changed before it was taken");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        dram_req_valid && !dram_req_ready |=> dram_req_valid && $stable(dram_req))
    else begin
        $error("DRAM request dropped or changed before it was taken");
        fail_count++;
    end

    // Idle is the only state that takes a request
    assert property (@(posedge clk) disable iff (!arst_n)
        !(core_req_ready && (core_rsp_valid || dram_req_valid)))
    else begin
        $error("request ready while a response or DRAM request is pending");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        !(dram_rsp_ready && dram_req_valid))
    else begin
        $error("DRAM response ready while a DRAM request is pending");
        fail_count++;
    end

endmodule

bind cache_top cache_checker checker_inst (.*);

`default_nettype wire

// ==== verification/tb_cache_model.svh ====
// DRAM byte image covering the whole address pool
logic [7:0] dram_mem  [0:1023];
logic       exp_valid [0:15];
addr_tag_t  exp_tag   [0:15];

// Bank and set together pick one of sixteen cache slots
function automatic int slot_of(word_addr_t a);
    return int'({a[5:3], a[2]});
endfunction

function automatic void reset_model();
    for (int a = 0; a < 1024; a++) begin
        dram_mem[a] = 8'(a) ^ {4{2'(a >> 8)}} ^ 8'h3c;
    end
    for (int s = 0; s < 16; s++) begin
        exp_valid[s] = 1'b0;
        exp_tag[s]   = '0;
    end
endfunction

function automatic word_t mem_word(word_addr_t a);
    word_t w;
    for (int b = 0; b < 4; b++) begin
        w[b*8 +: 8] = dram_mem[{a[7:0], 2'(b)}];
    end
    return w;
endfunction

function automatic line_t line_from_mem(line_addr_t la);
    line_t l;
    for (int i = 0; i < 16; i++) begin
        l[i*8 +: 8] = dram_mem[{la[5:0], 4'(i)}];
    end
    return l;
endfunction

function automatic logic is_resident(word_addr_t a);
    return exp_valid[slot_of(a)] && (exp_tag[slot_of(a)] == a[15:6]);
endfunction

function automatic void mark_resident(word_addr_t a);
    exp_valid[slot_of(a)] = 1'b1;
    exp_tag[slot_of(a)]   = a[15:6];
endfunction

function automatic void write_mem(line_addr_t la, line_byteen_t be, line_t data);
    for (int i = 0; i < 16; i++) begin
        if (be[i]) begin
            dram_mem[{la[5:0], 4'(i)}] = data[i*8 +: 8];
        end
    end
endfunction

function automatic line_byteen_t lane_enables(word_addr_t a, word_byteen_t be);
    return line_byteen_t'(be) << (4 * a[1:0]);
endfunction

// ==== verification/tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache;

    import cache_pkg::*;

    localparam int num_directed   = 5;
    localparam int num_random     = 300;
    // A random write may be followed by a read of the same word
    localparam int timeout_cycles = (num_directed + 2 * num_random) * 40;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      core_req_valid;
    core_req_t core_req;
    logic      core_req_ready;
    logic      core_rsp_valid;
    core_rsp_t core_rsp;
    logic      core_rsp_ready;
    logic      dram_req_valid;
    dram_req_t dram_req;
    logic      dram_req_ready;
    logic      dram_rsp_valid;
    dram_rsp_t dram_rsp;
    logic      dram_rsp_ready;

    logic [31:0] rng_state = 32'd7;
    int          cycle = 0;
    int          error_cnt = 0;
    int          op_cnt = 0;
    int          read_cnt = 0;
    int          rsp_cnt = 0;
    int          dram_req_cnt = 0;
    int          acc_edge;
    int          rsp_first_edge;
    logic        rsp_seen;
    core_rsp_t   last_rsp;
    dram_req_t   last_dram_req;
    logic        fill_pending = 1'b0;
    logic        fill_done = 1'b0;
    int          fill_delay;
    line_addr_t  fill_addr;

    `include "tb_cache_model.svh"

    cache_top cache_top_inst (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic report_error(input string msg);
        error_cnt++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        cycle++;
        if (cycle > timeout_cycles) begin
            $display("Timeout: run exceeded %0d cycles", timeout_cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Back-pressure and the DRAM fill responder
    always @(posedge clk) begin : bus_drive
        logic [31:0] r;
        logic        active;
        active = arst_n;
        #1;
        if (active) begin
            r = next_rand();
            core_rsp_ready = (r[1:0] != 2'b00);
            dram_req_ready = (r[3:2] != 2'b00);
            if (fill_done) begin
                dram_rsp_valid = 1'b0;
                fill_done      = 1'b0;
            end else if (fill_pending) begin
                if (fill_delay == 0) begin
                    dram_rsp_valid = 1'b1;
                    dram_rsp.tag   = fill_addr;
                    dram_rsp.data  = line_from_mem(fill_addr);
                    fill_pending   = 1'b0;
                end else begin
                    fill_delay--;
                end
            end
        end
    end

    // Transfers seen at mid-cycle complete at the next edge
    always @(negedge clk) begin
        if (dram_req_valid && dram_req_ready) begin
            last_dram_req = dram_req;
            if (dram_req.rw) begin
                write_mem(dram_req.addr, dram_req.byteen, dram_req.data);
            end else begin
                fill_pending = 1'b1;
                fill_addr    = dram_req.addr;
                fill_delay   = int'(next_rand() & 32'h7);
            end
            dram_req_cnt++;
        end
        if (dram_rsp_valid && dram_rsp_ready) begin
            fill_done = 1'b1;
        end
        if (core_req_valid && core_req_ready) begin
            acc_edge = cycle + 1;
        end
        if (core_rsp_valid && !rsp_seen) begin
            rsp_seen       = 1'b1;
            rsp_first_edge = cycle + 1;
        end
        if (core_rsp_valid && core_rsp_ready) begin
            last_rsp = core_rsp;
            rsp_cnt++;
        end
    end

    task automatic run_op(input logic rw, input word_addr_t addr, input word_byteen_t be,
                          input word_t data);
        int        dram_before;
        int        rsp_before;
        logic      resident;
        core_tag_t tag;
        word_t     exp_word;
        dram_req_t req;
        tag         = core_tag_t'(next_rand());
        resident    = is_resident(addr);
        dram_before = dram_req_cnt;
        rsp_before  = rsp_cnt;
        rsp_seen    = 1'b0;
        op_cnt++;
        @(posedge clk);
        #1;
        core_req_valid = 1'b1;
        core_req       = {rw, be, addr, data, tag};
        do @(negedge clk); while (!core_req_ready);
        @(posedge clk);
        #1;
        core_req_valid = 1'b0;
        if (!rw) begin
            read_cnt++;
            wait (rsp_cnt != rsp_before);
            exp_word = mem_word(addr);
            if (last_rsp.data !== exp_word || last_rsp.tag !== tag) begin
                report_error($sformatf("read %h returned %h tag %h, expected %h tag %h",
                    addr, last_rsp.data, last_rsp.tag, exp_word, tag));
            end
            if (resident) begin
                if (dram_req_cnt != dram_before) begin
                    report_error($sformatf("read hit at %h issued a DRAM request", addr));
                end
                if (rsp_first_edge != acc_edge + 2) begin
                    report_error($sformatf("read hit at %h responded at edge %0d, expected %0d",
                        addr, rsp_first_edge, acc_edge + 2));
                end
            end else begin
                req = last_dram_req;
                if (dram_req_cnt != dram_before + 1) begin
                    report_error($sformatf("read miss at %h issued %0d DRAM requests",
                        addr, dram_req_cnt - dram_before));
                end
                if (req.rw !== 1'b0 || req.byteen !== '1 || req.addr !== addr[15:2]) begin
                    report_error($sformatf("bad fill request rw %b be %h addr %h for %h",
                        req.rw, req.byteen, req.addr, addr));
                end
                mark_resident(addr);
            end
        end else begin
            wait (dram_req_cnt != dram_before);
            req = last_dram_req;
            if (req.rw !== 1'b1 || req.addr !== addr[15:2] ||
                req.byteen !== lane_enables(addr, be) ||
                req.data[addr[1:0]*32 +: 32] !== data) begin
                report_error($sformatf("bad write-through rw %b be %h addr %h for %h",
                    req.rw, req.byteen, req.addr, addr));
            end
            if (rsp_cnt != rsp_before) begin
                report_error($sformatf("write to %h produced a core response", addr));
            end
        end
    endtask

    task automatic print_test(input string name, input int ops, input int errs_before);
        $display("test %s: %0d ops, %0d errors", name, ops, error_cnt - errs_before);
    endtask

    initial begin
        int          errs_before;
        int          ops_before;
        logic [31:0] r;
        word_addr_t  addr;
        arst_n         = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        core_rsp_ready = 1'b0;
        dram_req_ready = 1'b0;
        dram_rsp_valid = 1'b0;
        dram_rsp       = '0;
        reset_model();
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        errs_before = error_cnt;
        @(negedge clk);
        if (core_req_ready !== 1'b1 || core_rsp_valid !== 1'b0 ||
            dram_req_valid !== 1'b0 || dram_rsp_ready !== 1'b0) begin
            report_error("handshake outputs wrong after reset");
        end
        print_test("reset_state", 0, errs_before);

        // Merge on a non-resident line and then on a resident one
        errs_before = error_cnt;
        ops_before  = op_cnt;
        run_op(1'b1, 16'h00c5, 4'b1001, 32'ha1b2c3d4);
        run_op(1'b0, 16'h00c5, 4'b0000, 32'h0);
        run_op(1'b0, 16'h0041, 4'b0000, 32'h0);
        run_op(1'b1, 16'h0041, 4'b0110, 32'h11223344);
        run_op(1'b0, 16'h0041, 4'b0000, 32'h0);
        print_test("partial_write_merge", op_cnt - ops_before, errs_before);

        errs_before = error_cnt;
        ops_before  = op_cnt;
        for (int i = 0; i < num_random; i++) begin
            r    = next_rand();
            addr = word_addr_t'(r[15:0]) & 16'h00cf;
            run_op(r[16], addr, r[20:17], next_rand());
            if (r[16] && r[21]) begin
                run_op(1'b0, addr, 4'b0000, 32'h0);
            end
        end
        print_test("random_traffic", op_cnt - ops_before, errs_before);

        repeat (4) @(posedge clk);
        if (rsp_cnt != read_cnt) begin
            report_error($sformatf("%0d responses for %0d reads", rsp_cnt, read_cnt));
        end
        if (cache_top_inst.checker_inst.fail_count != 0) begin
            $display("Assertion failures seen: %0d", cache_top_inst.checker_inst.fail_count);
            error_cnt += cache_top_inst.checker_inst.fail_count;
        end
        $display("summary: %0d ops, %0d reads, %0d responses, %0d errors",
            op_cnt, read_cnt, rsp_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verification
rtl/cache_pkg.sv
rtl/line_store.sv
rtl/bank_router.sv
rtl/cache_ctrl.sv
rtl/cache_top.sv
verification/cache_checker.sv
verification/tb_cache.sv
